// ==== Makefile ====
# Verilator simulation of the decimal adjust unit

VERILATOR ?= verilator
TOP       ?= bcd_adj_tb
FILELIST  ?= bcd_adj.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# Build, run, then scan the log for the fail message
sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
	  -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TEST FAILED" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== bcd_adj.f ====
+incdir+include
source/bcd_ops_pkg.sv
source/bcd_flags_pkg.sv
source/div10_array.sv
source/bcd_adjust_core.sv
source/bcd_result_select.sv
source/bcd_adj_top.sv
testbench/bcd_adj_assertions.sv
testbench/bcd_adj_tb.sv

// ==== include/bcd_adj_cfg.svh ====
/*
  Decimal adjust unit widths
  Word, byte and BCD digit sizes of the x86 AX register and its halves
*/
`ifndef BCD_ADJ_CFG_SVH
`define BCD_ADJ_CFG_SVH

// Full AX register
`define BCD_ADJ_WORD_W 16

// AL or AH half
`define BCD_ADJ_BYTE_W 8

// One packed or unpacked BCD digit
`define BCD_ADJ_DIGIT_W 4

`endif

// ==== source/bcd_adj_top.sv ====
/*
  Decimal adjust unit
  Four-phase req/ack front end around a divider path and an adjust
  path that run side by side, merged by a registered result selector
  ack rises two edges after req is taken and falls once req drops
*/
`timescale 1ns/1ps
`include "bcd_adj_cfg.svh"

module bcd_adj_top
  import bcd_ops_pkg::*;
  import bcd_flags_pkg::*;
(
  input  logic     clk,
  input  logic     arst_n,
  input  logic     req,
  input  bcd_req_t cmd,
  output logic     ack,
  output bcd_res_t res
);

  typedef enum logic [1:0] {
    HS_IDLE,
    HS_CALC,
    HS_ACK
  } hs_state_e;

  hs_state_e state;
  hs_state_e state_nxt;
  logic      ack_nxt;

  // Captured request, feeds both datapaths
  bcd_req_t cmd_q;
  logic     take;
  logic     load;

  // Datapath results
  logic [`BCD_ADJ_DIGIT_W:0]   quot;
  logic [`BCD_ADJ_DIGIT_W-1:0] rem;
  bcd_res_t                    adj_res;

  // Request accepted only from idle
  assign take = (state == HS_IDLE) & req;

  // Selector register loads one edge after capture
  assign load = (state == HS_CALC);

  always_comb begin
    state_nxt = state;
    ack_nxt   = ack;
    case (state)
      HS_IDLE: begin
        if (req) begin
          state_nxt = HS_CALC;
        end
      end
      HS_CALC: begin
        state_nxt = HS_ACK;
      end
      HS_ACK: begin
        // First edge here raises ack, then wait for req to drop
        if (!ack) begin
          ack_nxt = 1'b1;
        end else if (!req) begin
          ack_nxt   = 1'b0;
          state_nxt = HS_IDLE;
        end
      end
      default: begin
        state_nxt = HS_IDLE;
        ack_nxt   = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= HS_IDLE;
      ack   <= 1'b0;
    end else begin
      state <= state_nxt;
      ack   <= ack_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cmd_q <= cmd;
    end
  end

  // Divider only sees AL
  div10_array u_div (
    .dividend (cmd_q.ax[`BCD_ADJ_BYTE_W-1:0]),
    .quot     (quot),
    .rem      (rem)
  );

  bcd_adjust_core u_adj (
    .cmd     (cmd_q),
    .adj_res (adj_res)
  );

  bcd_result_select u_sel (
    .clk     (clk),
    .arst_n  (arst_n),
    .load    (load),
    .op      (cmd_q.op),
    .quot    (quot),
    .rem     (rem),
    .adj_res (adj_res),
    .res     (res)
  );

endmodule

// ==== source/bcd_adjust_core.sv ====
/*
  BCD adjust path
  Nibble correction for DAA, DAS, AAA and AAS, and the
  multiply-by-ten-and-add of AAD
  Produces AX with valid CF and AF, other flags left zero
*/
`timescale 1ns/1ps
`include "bcd_adj_cfg.svh"

module bcd_adjust_core
  import bcd_ops_pkg::*;
  import bcd_flags_pkg::*;
(
  input  bcd_req_t cmd,
  output bcd_res_t adj_res
);

  // Register halves
  logic [`BCD_ADJ_BYTE_W-1:0] al;
  logic [`BCD_ADJ_BYTE_W-1:0] ah;

  // Correction conditions
  logic lo_fix;
  logic hi_fix;

  // Low digit corrected by six
  logic [`BCD_ADJ_BYTE_W-1:0] al_lo_add;
  logic [`BCD_ADJ_BYTE_W-1:0] al_lo_sub;

  // Packed results
  logic [`BCD_ADJ_BYTE_W-1:0] daa_al;
  logic [`BCD_ADJ_BYTE_W-1:0] das_al;

  // AAD terms
  logic [`BCD_ADJ_BYTE_W-1:0] ah_x10;
  logic [`BCD_ADJ_BYTE_W-1:0] aad_al;

  // Selected outputs
  logic [`BCD_ADJ_BYTE_W-1:0] new_al;
  logic [`BCD_ADJ_BYTE_W-1:0] new_ah;
  logic                       new_cf;
  logic                       new_af;

  assign al = cmd.ax[`BCD_ADJ_BYTE_W-1:0];
  assign ah = cmd.ax[`BCD_ADJ_WORD_W-1:`BCD_ADJ_BYTE_W];

  // Low digit out of range or a half carry came in
  assign lo_fix = (al[`BCD_ADJ_DIGIT_W-1:0] > 4'd9) | cmd.af;

  // Whole byte past 99 or a carry came in, judged on the original AL
  assign hi_fix = (al > 8'h99) | cmd.cf;

  assign al_lo_add = al + 8'h06;
  assign al_lo_sub = al - 8'h06;

  // Second step works on the low-corrected value
  assign daa_al = (lo_fix ? al_lo_add : al) + (hi_fix ? 8'h60 : 8'h00);
  assign das_al = (lo_fix ? al_lo_sub : al) - (hi_fix ? 8'h60 : 8'h00);

  // AH times ten as AH*8 plus AH*2, wrapping at a byte
  assign ah_x10 = {ah[`BCD_ADJ_BYTE_W-4:0], 3'b000} + {ah[`BCD_ADJ_BYTE_W-2:0], 1'b0};
  assign aad_al = ah_x10 + al;

  always_comb begin
    // Defaults leave AX as it came, flags cleared
    new_al = al;
    new_ah = ah;
    new_cf = 1'b0;
    new_af = 1'b0;
    case (cmd.op)
      OP_DAA: begin
        new_al = daa_al;
        new_af = lo_fix;
        new_cf = hi_fix;
      end
      OP_DAS: begin
        new_al = das_al;
        new_af = lo_fix;
        new_cf = hi_fix;
      end
      OP_AAA: begin
        // Unpacked form keeps only the low digit
        if (lo_fix) begin
          new_al = al_lo_add & 8'h0f;
          new_ah = ah + 8'd1;
          new_af = 1'b1;
          new_cf = 1'b1;
        end else begin
          new_al = al & 8'h0f;
        end
      end
      OP_AAS: begin
        if (lo_fix) begin
          new_al = al_lo_sub & 8'h0f;
          new_ah = ah - 8'd1;
          new_af = 1'b1;
          new_cf = 1'b1;
        end else begin
          new_al = al & 8'h0f;
        end
      end
      OP_AAD: begin
        new_al = aad_al;
        new_ah = 8'h00;
      end
      // AAM comes from the divider path
      default: begin
      end
    endcase
  end

  always_comb begin
    adj_res          = '0;
    adj_res.ax       = {new_ah, new_al};
    adj_res.flags.cf = new_cf;
    adj_res.flags.af = new_af;
  end

endmodule

// ==== source/bcd_flags_pkg.sv ====
/*
  Decimal adjust result types
  Arithmetic flag group and the answer word returned by the unit
*/
`include "bcd_adj_cfg.svh"

package bcd_flags_pkg;

  // Five arithmetic flags, overflow not modelled
  typedef struct packed {
    logic cf;
    logic af;
    // AL zero
    logic zf;
    // AL bit 7
    logic sf;
    // Even count of ones in AL
    logic pf;
  } bcd_flags_t;

  // Adjusted register and its flags
  typedef struct packed {
    logic [`BCD_ADJ_WORD_W-1:0] ax;
    bcd_flags_t                 flags;
  } bcd_res_t;

endpackage

// ==== source/bcd_ops_pkg.sv ====
/*
  Decimal adjust operation types
  Opcode encoding and the request word handed to the unit
*/
`include "bcd_adj_cfg.svh"

package bcd_ops_pkg;

  // Adjust opcodes, base is always ten
  typedef enum logic [2:0] {
    OP_AAM = 3'd0,
    OP_AAD = 3'd1,
    OP_DAA = 3'd2,
    OP_DAS = 3'd3,
    OP_AAA = 3'd4,
    OP_AAS = 3'd5
  } bcd_op_e;

  // One request from the execution core
  typedef struct packed {
    bcd_op_e                    op;
    // AH in the upper byte, AL in the lower
    logic [`BCD_ADJ_WORD_W-1:0] ax;
    // Incoming carry
    logic                       cf;
    // Incoming auxiliary carry
    logic                       af;
  } bcd_req_t;

endpackage

// ==== source/bcd_result_select.sv ====
/*
  Result selector
  Chooses the divider answer for AAM or the adjust answer otherwise,
  derives ZF, SF and PF from the final AL and registers the result
*/
`timescale 1ns/1ps
`include "bcd_adj_cfg.svh"

module bcd_result_select
  import bcd_ops_pkg::*;
  import bcd_flags_pkg::*;
(
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        load,
  input  bcd_op_e                     op,
  input  logic [`BCD_ADJ_DIGIT_W:0]   quot,
  input  logic [`BCD_ADJ_DIGIT_W-1:0] rem,
  input  bcd_res_t                    adj_res,
  output bcd_res_t                    res
);

  // Combinational answer before the register
  bcd_res_t sel_res;

  // AL of the chosen answer, drives the status flags
  logic [`BCD_ADJ_BYTE_W-1:0] sel_al;

  always_comb begin
    sel_res = adj_res;

    // AAM puts tens in AH and units in AL
    if (op == OP_AAM) begin
      sel_res.ax = {{(`BCD_ADJ_BYTE_W-`BCD_ADJ_DIGIT_W-1){1'b0}}, quot,
                    {(`BCD_ADJ_BYTE_W-`BCD_ADJ_DIGIT_W){1'b0}}, rem};
      sel_res.flags.cf = 1'b0;
      sel_res.flags.af = 1'b0;
    end

    sel_al = sel_res.ax[`BCD_ADJ_BYTE_W-1:0];

    // Status flags look at AL only, for every opcode
    sel_res.flags.zf = (sel_al == '0);
    sel_res.flags.sf = sel_al[`BCD_ADJ_BYTE_W-1];
    // Set on an even number of ones
    sel_res.flags.pf = ~^sel_al;
  end

  // Holds the answer between loads, so it is steady while ack is up
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      res <= '0;
    end else if (load) begin
      res <= sel_res;
    end
  end

endmodule

// ==== source/div10_array.sv ====
/*
  Byte divided by ten
  Chain of five restoring one-bit cells, each comparing the partial
  remainder against ten, giving a 5-bit quotient and a 4-bit remainder
*/
`timescale 1ns/1ps
`include "bcd_adj_cfg.svh"

module div10_array (
  input  logic [`BCD_ADJ_BYTE_W-1:0]  dividend,
  output logic [`BCD_ADJ_DIGIT_W:0]   quot,
  output logic [`BCD_ADJ_DIGIT_W-1:0] rem
);

  // Partial remainders between the cells
  // Entry 0 feeds the first cell, the last entry is the final remainder
  logic [`BCD_ADJ_DIGIT_W-1:0] part [0:`BCD_ADJ_DIGIT_W+1];

  // Top three dividend bits are below ten, so no step is needed for them
  assign part[0] = {1'b0, dividend[`BCD_ADJ_BYTE_W-1:`BCD_ADJ_DIGIT_W+1]};

  for (genvar i = 0; i <= `BCD_ADJ_DIGIT_W; i++) begin : g_cell
    // Shifted remainder with the next dividend bit appended
    logic [`BCD_ADJ_DIGIT_W:0] trial;
    logic                      q_bit;

    assign trial = {part[i], dividend[`BCD_ADJ_DIGIT_W-i]};

    // Ten fits whenever the trial value reaches it
    assign q_bit = (trial >= 5'd10);

    // Cell 0 makes the quotient MSB
    assign quot[`BCD_ADJ_DIGIT_W-i] = q_bit;

    // Restore by keeping the trial, else drop ten
    // Result stays below ten so four bits are enough
    assign part[i+1] = q_bit ? (trial[`BCD_ADJ_DIGIT_W-1:0] - 4'd10)
                             : trial[`BCD_ADJ_DIGIT_W-1:0];
  end

  // Last cell output is the remainder
  assign rem = part[`BCD_ADJ_DIGIT_W+1];

endmodule

// ==== testbench/bcd_adj_assertions.sv ====
/*
  Handshake checks for the decimal adjust unit
  Bound into the top level, watches req, ack and the result word
*/
`timescale 1ns/1ps

module bcd_adj_assertions
  import bcd_flags_pkg::*;
(
  input logic     clk,
  input logic     arst_n,
  input logic     req,
  input logic     ack,
  input bcd_res_t res
);

  // Reset keeps the acknowledge down
  ack_low_in_reset: assert property (@(posedge clk) !arst_n |-> !ack)
    else $error("ack high while reset is asserted");

  // Rise only answers a request that is still up
  ack_rise_needs_req: assert property (@(posedge clk) disable iff (!arst_n)
    $rose(ack) |-> $past(req))
    else $error("ack rose without req");

  // Answer held for the whole acknowledge phase
  res_stable_in_ack: assert property (@(posedge clk) disable iff (!arst_n)
    ack |=> $stable(res))
    else $error("res changed while ack was high");

  // Fall only once the requester has let go
  ack_fall_after_req: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(ack) |-> !$past(req))
    else $error("ack fell while req was still high");

endmodule

bind bcd_adj_top bcd_adj_assertions u_asrt (
  .clk    (clk),
  .arst_n (arst_n),
  .req    (req),
  .ack    (ack),
  .res    (res)
);

// ==== testbench/bcd_adj_tb.sv ====
/*
  Testbench for the decimal adjust unit
  Runs AAM, AAD, DAA, DAS, AAA and AAS through the req/ack handshake,
  checks every answer against a reference model and the handshake timing
*/
`timescale 1ns/1ps
`include "bcd_adj_cfg.svh"

module bcd_adj_tb
  import bcd_ops_pkg::*;
  import bcd_flags_pkg::*;
;

  localparam int ACK_TIMEOUT = 50;
  localparam int MAX_HOLD    = 10;

  logic     clk;
  logic     arst_n;
  logic     req;
  bcd_req_t cmd;
  logic     ack;
  bcd_res_t res;

  // Expected answers in request order
  bcd_res_t exp_q [$];
  int       n_sent = 0;
  int       n_done = 0;
  logic     ack_d  = 1'b0;

  bcd_adj_top u_dut (
    .clk    (clk),
    .arst_n (arst_n),
    .req    (req),
    .cmd    (cmd),
    .ack    (ack),
    .res    (res)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("ERROR at %0t: %s", $time, why);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("MISMATCH time=%0t signal=%s got=0x%0h exp=0x%0h", $time, name, got, want);
      $display("TEST FAILED");
      $fatal(1);
    end
  endtask

  // Expected AX and flags straight from the x86 adjust rules
  function automatic bcd_res_t bcd_model(input bcd_req_t c);
    int         al;
    int         ah;
    int         al_in;
    int         ones;
    logic       cf;
    logic       af;
    logic [7:0] al_b;
    bcd_res_t   r;
    al    = int'(c.ax[7:0]);
    ah    = int'(c.ax[15:8]);
    al_in = al;
    cf    = 1'b0;
    af    = 1'b0;
    case (c.op)
      OP_AAM: begin
        ah = al_in / 10;
        al = al_in % 10;
      end
      OP_AAD: begin
        al = (ah * 10 + al_in) % 256;
        ah = 0;
      end
      OP_DAA, OP_DAS: begin
        // Low digit first, then the high digit judged on the original AL
        if ((al_in % 16) > 9 || c.af) begin
          al = (c.op == OP_DAA) ? (al + 6) % 256 : (al + 250) % 256;
          af = 1'b1;
        end
        if (al_in > 'h99 || c.cf) begin
          al = (c.op == OP_DAA) ? (al + 'h60) % 256 : (al + 256 - 'h60) % 256;
          cf = 1'b1;
        end
      end
      OP_AAA, OP_AAS: begin
        if ((al_in % 16) > 9 || c.af) begin
          al = (c.op == OP_AAA) ? (al_in + 6) % 16 : (al_in + 250) % 16;
          ah = (c.op == OP_AAA) ? (ah + 1) % 256 : (ah + 255) % 256;
          af = 1'b1;
          cf = 1'b1;
        end else begin
          al = al_in % 16;
        end
      end
      default: begin
      end
    endcase
    al_b = 8'(al);
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (al_b[i]) ones++;
    end
    r.ax       = {8'(ah), al_b};
    r.flags.cf = cf;
    r.flags.af = af;
    r.flags.zf = (al == 0);
    r.flags.sf = (al >= 128);
    // Parity of the low byte, set when even
    r.flags.pf = ((ones % 2) == 0);
    return r;
  endfunction

  function automatic bcd_req_t pack_req(input bcd_op_e op, input logic [15:0] ax,
                                        input logic cf, input logic af);
    bcd_req_t c;
    c.op = op;
    c.ax = ax;
    c.cf = cf;
    c.af = af;
    return c;
  endfunction

  // One full four-phase transfer with a random hold of req
  task automatic run_op(input bcd_req_t c);
    int       cnt;
    int       hold;
    bcd_res_t held;
    hold = $urandom_range(MAX_HOLD, 0);
    exp_q.push_back(bcd_model(c));
    n_sent++;
    @(negedge clk);
    cmd = c;
    req = 1'b1;
    cnt = 0;
    while (ack !== 1'b1) begin
      if (cnt >= ACK_TIMEOUT) stop_run("timed out waiting for ack to rise");
      @(negedge clk);
      cnt++;
    end
    // Sampled at edge N, ack up after edge N+2
    check_eq("ack_rise_latency", cnt, 3);
    held = res;
    repeat (hold) begin
      @(negedge clk);
      check_eq("ack", 32'(ack), 1);
      check_eq("res", 32'({res}), 32'({held}));
    end
    req    = 1'b0;
    // New AX after release must not reach the answer
    cmd.ax = 16'($urandom());
    cnt    = 0;
    while (ack !== 1'b0) begin
      if (cnt >= ACK_TIMEOUT) stop_run("timed out waiting for ack to fall");
      @(negedge clk);
      cnt++;
    end
    check_eq("ack_fall_latency", cnt, 1);
  endtask

  // Compares each answer on the first low phase of ack
  always @(negedge clk) begin : compare_proc
    bcd_res_t want;
    if (arst_n === 1'b1 && ack === 1'b1 && ack_d === 1'b0) begin
      if (exp_q.size() == 0) stop_run("ack rose with no request outstanding");
      want = exp_q.pop_front();
      check_eq("res.ax", 32'(res.ax), 32'(want.ax));
      check_eq("res.flags.cf", 32'(res.flags.cf), 32'(want.flags.cf));
      check_eq("res.flags.af", 32'(res.flags.af), 32'(want.flags.af));
      check_eq("res.flags.zf", 32'(res.flags.zf), 32'(want.flags.zf));
      check_eq("res.flags.sf", 32'(res.flags.sf), 32'(want.flags.sf));
      check_eq("res.flags.pf", 32'(res.flags.pf), 32'(want.flags.pf));
      n_done++;
    end
    ack_d = ack;
  end

  initial begin
    logic [7:0] corner_al [4];
    logic [7:0] al;
    bcd_op_e    op;
    req    = 1'b0;
    cmd    = '0;
    arst_n = 1'b0;
    void'($urandom(32'hd9e8_9e62));
    // Values around the 0x99 boundary and a bad low digit
    corner_al = '{8'h99, 8'h9a, 8'hff, 8'h0a};
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    check_eq("ack", 32'(ack), 0);
    check_eq("res", 32'({res}), 0);

    // AAM over every AL
    for (int v = 0; v < 256; v++) begin
      run_op(pack_req(OP_AAM, {8'($urandom()), 8'(v)}, 1'($urandom()), 1'($urandom())));
    end

    // AAD with random AX
    for (int n = 0; n < 48; n++) begin
      run_op(pack_req(OP_AAD, 16'($urandom()), 1'($urandom()), 1'($urandom())));
    end

    // DAA and DAS over all carry combinations
    for (int p = 0; p < 2; p++) begin
      op = (p == 0) ? OP_DAA : OP_DAS;
      for (int k = 0; k < 4; k++) begin
        for (int j = 0; j < 16; j++) begin
          al = (j < 4) ? corner_al[j] : 8'($urandom());
          run_op(pack_req(op, {8'($urandom()), al}, k[1], k[0]));
        end
      end
    end

    // AAA and AAS with af clear then set
    for (int p = 0; p < 2; p++) begin
      op = (p == 0) ? OP_AAA : OP_AAS;
      for (int a = 0; a < 2; a++) begin
        for (int n = 0; n < 20; n++) begin
          run_op(pack_req(op, 16'($urandom()), 1'($urandom()), a[0]));
        end
      end
    end

    repeat (2) @(negedge clk);
    if (exp_q.size() == 0 && n_done == n_sent) begin
      $display("TEST OK");
      $finish;
    end else begin
      $display("ERROR: %0d requests sent but %0d answers compared", n_sent, n_done);
      $display("TEST FAILED");
      $fatal(1);
    end
  end

endmodule
